// File: src/rs_pkg.sv
// Reservation station package
// Sizes, tag and value types, operand and entry structs shared by
// the station, the capture logic and the physical register file
`default_nettype none

package rs_pkg;

	// ==============================
	// Sizes
	// ==============================

	// Station entries
	localparam int NRSE = 4;
	// Dispatch lanes offered per cycle
	localparam int DISPATCH_LANES = 2;
	// Result buses
	localparam int NBYP = 2;
	// Register read request ports
	localparam int NRDPORT = 2;
	// Source operands per micro-op
	localparam int NSRC = 2;
	// Physical registers
	localparam int NPREG = 32;
	// Function-unit code served by this station
	localparam int MY_FUNCUNIT = 3;

	// ==============================
	// Plain vector types
	// ==============================

	typedef logic [$clog2(NPREG)-1:0] preg_t;
	typedef logic [31:0] value_t;
	typedef logic [3:0] rob_idx_t;
	// One bit per ROB index
	typedef logic [15:0] rob_mask_t;
	typedef logic [2:0] funcunit_t;
	// Index of a station entry
	typedef logic [$clog2(NRSE)-1:0] rse_idx_t;

	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_ADD = 4'd1,
		OP_SUB = 4'd2,
		OP_AND = 4'd3,
		OP_OR  = 4'd4,
		OP_XOR = 4'd5
	} opcode_e;

	// ==============================
	// Operand and entry
	// ==============================

	// On a bus or read answer v means value valid, in an entry v means captured
	typedef struct packed {
		preg_t  tag;
		value_t val;
		logic   v;
	} operand_t;

	typedef struct packed {
		logic                  v;
		logic                  busy;
		logic                  ready;
		funcunit_t             funcunit;
		opcode_e               op;
		rob_idx_t              rndx;
		preg_t                 dst;
		operand_t [NSRC-1:0]   src;
	} rs_entry_t;

	// Argument arrays
	typedef rs_entry_t [DISPATCH_LANES-1:0] lane_arr_t;
	typedef rs_entry_t [NRSE-1:0] ent_arr_t;
	typedef operand_t [NRSE-1:0][NSRC-1:0] ent_oper_arr_t;
	typedef operand_t [NBYP-1:0] byp_arr_t;
	typedef operand_t [NRDPORT-1:0] rdport_arr_t;
	typedef preg_t [NRDPORT-1:0] rdport_tag_t;

endpackage

`default_nettype wire

// File: src/operand_capture.sv
// Operand capture
// Matches every waiting operand tag against the register read answers
// and the result buses, result buses winning
`timescale 1ns/1ns
`default_nettype none

module operand_capture import rs_pkg::*; (
	input  ent_oper_arr_t ent_oper_i,
	input  rdport_arr_t   rd_oper_i,
	input  byp_arr_t      result_i,
	output ent_oper_arr_t cap_oper_o
);

	// True when a source offers a valid value for the waiting tag
	function automatic logic tag_hit(operand_t waiting, operand_t source);
		return source.v && (source.tag == waiting.tag);
	endfunction

	// ==============================
	// Capture
	// ==============================

	always_comb begin
		// Captured operands pass through untouched
		cap_oper_o = ent_oper_i;
		for (int i = 0; i < NRSE; i++) begin
			for (int s = 0; s < NSRC; s++) begin
				if (!ent_oper_i[i][s].v) begin
					// Register file answers first
					for (int p = 0; p < NRDPORT; p++) begin
						if (tag_hit(ent_oper_i[i][s], rd_oper_i[p])) begin
							cap_oper_o[i][s].val = rd_oper_i[p].val;
							cap_oper_o[i][s].v = 1'b1;
						end
					end
					// Result buses override, they carry the newest value
					for (int b = 0; b < NBYP; b++) begin
						if (tag_hit(ent_oper_i[i][s], result_i[b])) begin
							cap_oper_o[i][s].val = result_i[b].val;
							cap_oper_o[i][s].v = 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/phys_regfile.sv
// Physical register file with valid bits
// Written by the result buses, invalidated by dispatch allocation,
// answers read requests one cycle later
`timescale 1ns/1ns
`default_nettype none

module phys_regfile import rs_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  rdport_tag_t        req_tag_i,
	input  logic [NRDPORT-1:0] req_v_i,
	input  preg_t              alloc_tag_i,
	input  logic               alloc_v_i,
	input  byp_arr_t           result_i,
	output rdport_arr_t        rd_oper_o
);

	// Register values
	value_t regs [NPREG];
	// Register holds its final value
	logic [NPREG-1:0] valid;

	// ==============================
	// Storage
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			// All registers come up valid at zero
			for (int r = 0; r < NPREG; r++)
				regs[r] <= '0;
			valid <= '1;
		end
		else begin
			// Result buses write value and set valid
			for (int b = 0; b < NBYP; b++) begin
				if (result_i[b].v) begin
					regs[result_i[b].tag] <= result_i[b].val;
					valid[result_i[b].tag] <= 1'b1;
				end
			end
			// New producer allocated, value pending
			// Placed last so it beats a write to the same tag
			if (alloc_v_i)
				valid[alloc_tag_i] <= 1'b0;
		end
	end

	// ==============================
	// Read answers
	// ==============================

	// Registered, so a request in one cycle is answered in the next
	// Invalid registers answer with v low and get asked again
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_oper_o <= '0;
		end
		else begin
			for (int p = 0; p < NRDPORT; p++) begin
				rd_oper_o[p].tag <= req_tag_i[p];
				rd_oper_o[p].val <= regs[req_tag_i[p]];
				rd_oper_o[p].v <= req_v_i[p] && valid[req_tag_i[p]];
			end
		end
	end

endmodule

`default_nettype wire

// File: src/rs_station.sv
// Reservation station for one functional unit
// Takes the matching dispatch lane, holds four entries, wakes up operands,
// issues the highest ready entry and asks the register file for missing operands
`timescale 1ns/1ns
`default_nettype none

module rs_station import rs_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  lane_arr_t          dispatch_i,
	input  logic               available_i,
	input  logic               stall_i,
	input  rob_mask_t          stomp_i,
	input  ent_oper_arr_t      cap_oper_i,
	output ent_oper_arr_t      ent_oper_o,
	output rdport_tag_t        req_tag_o,
	output logic [NRDPORT-1:0] req_v_o,
	output preg_t              alloc_tag_o,
	output logic               alloc_v_o,
	output logic               busy_o,
	output logic               issue_o,
	output rs_entry_t          issue_entry_o
);

	ent_arr_t ent;
	// Stall seen in the previous cycle
	logic pstall;

	rs_entry_t lane_ent;
	logic lane_hit;
	rse_idx_t free_idx;
	logic free_hit;
	rse_idx_t rdy_idx;
	logic rdy_hit;
	logic accept;
	logic do_issue;

	// All source operands captured
	function automatic logic all_captured(operand_t [NSRC-1:0] src);
		logic ok;
		ok = 1'b1;
		for (int s = 0; s < NSRC; s++)
			ok = ok & src[s].v;
		return ok;
	endfunction

	// ==============================
	// Selection
	// ==============================

	always_comb begin
		for (int i = 0; i < NRSE; i++)
			ent_oper_o[i] = ent[i].src;
	end

	// Station is full when every entry is busy
	always_comb begin
		busy_o = 1'b1;
		for (int i = 0; i < NRSE; i++)
			busy_o = busy_o & ent[i].busy;
	end

	// Highest lane for this unit wins
	always_comb begin
		lane_ent = '0;
		lane_hit = 1'b0;
		for (int l = 0; l < DISPATCH_LANES; l++) begin
			if (dispatch_i[l].v && dispatch_i[l].funcunit == funcunit_t'(MY_FUNCUNIT)) begin
				lane_ent = dispatch_i[l];
				lane_hit = 1'b1;
			end
		end
	end

	// Highest free entry and highest ready entry
	always_comb begin
		free_idx = '0;
		free_hit = 1'b0;
		rdy_idx = '0;
		rdy_hit = 1'b0;
		for (int i = 0; i < NRSE; i++) begin
			if (!ent[i].busy) begin
				free_idx = rse_idx_t'(i);
				free_hit = 1'b1;
			end
			if (ent[i].ready) begin
				rdy_idx = rse_idx_t'(i);
				rdy_hit = 1'b1;
			end
		end
	end

	assign accept = available_i && lane_hit && free_hit;
	// Destination goes pending in the register file
	assign alloc_v_o = accept;
	assign alloc_tag_o = lane_ent.dst;
	// No issue while stalled or just out of a stall
	assign do_issue = !stall_i && !pstall && rdy_hit;

	// ==============================
	// Entry update
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			ent <= '0;
			pstall <= 1'b0;
			issue_o <= 1'b0;
		end
		else begin
			pstall <= stall_i;
			issue_o <= do_issue;
			for (int i = 0; i < NRSE; i++) begin
				// Wakeup from read answers and result buses
				if (ent[i].busy)
					ent[i].src <= cap_oper_i[i];
				// Ready lags the last capture by a cycle
				ent[i].ready <= ent[i].busy && all_captured(ent[i].src);
			end
			// Issued entry is freed
			if (do_issue) begin
				ent[rdy_idx].busy <= 1'b0;
				ent[rdy_idx].ready <= 1'b0;
			end
			// Load the selected lane, stomped ones become NOP
			if (accept) begin
				ent[free_idx] <= lane_ent;
				ent[free_idx].busy <= 1'b1;
				ent[free_idx].ready <= 1'b0;
				if (stomp_i[lane_ent.rndx])
					ent[free_idx].op <= OP_NOP;
			end
		end
	end

	// Issued micro-op, held until the next issue
	always_ff @(posedge clk) begin
		if (do_issue) begin
			issue_entry_o <= ent[rdy_idx];
			issue_entry_o.v <= ent[rdy_idx].v & ~stomp_i[ent[rdy_idx].rndx];
			if (stomp_i[ent[rdy_idx].rndx])
				issue_entry_o.op <= OP_NOP;
		end
	end

	// ==============================
	// Register read requests
	// ==============================

	// Busy entries in index order fill the read ports
	always_comb begin
		int slot;
		slot = 0;
		req_tag_o = '0;
		req_v_o = '0;
		for (int i = 0; i < NRSE; i++) begin
			for (int s = 0; s < NSRC; s++) begin
				if (ent[i].busy && !ent[i].src[s].v && slot < NRDPORT) begin
					req_tag_o[slot] = ent[i].src[s].tag;
					req_v_o[slot] = 1'b1;
					slot = slot + 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/rs_top.sv
// Reservation station top level
// Station, operand capture and physical register file wired together
`timescale 1ns/1ns
`default_nettype none

module rs_top import rs_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  lane_arr_t dispatch_i,
	input  logic      available_i,
	input  logic      stall_i,
	input  rob_mask_t stomp_i,
	input  byp_arr_t  result_i,
	output logic      busy_o,
	output logic      issue_o,
	output rs_entry_t issue_entry_o
);

	// Entry operands out and captured operands back
	ent_oper_arr_t ent_oper;
	ent_oper_arr_t cap_oper;
	// Read requests and answers
	rdport_tag_t req_tag;
	logic [NRDPORT-1:0] req_v;
	rdport_arr_t rd_oper;
	// Destination allocation on dispatch
	preg_t alloc_tag;
	logic alloc_v;

	rs_station rs_station_inst (
		.clk           (clk),
		.rst           (rst),
		.dispatch_i    (dispatch_i),
		.available_i   (available_i),
		.stall_i       (stall_i),
		.stomp_i       (stomp_i),
		.cap_oper_i    (cap_oper),
		.ent_oper_o    (ent_oper),
		.req_tag_o     (req_tag),
		.req_v_o       (req_v),
		.alloc_tag_o   (alloc_tag),
		.alloc_v_o     (alloc_v),
		.busy_o        (busy_o),
		.issue_o       (issue_o),
		.issue_entry_o (issue_entry_o)
	);

	operand_capture operand_capture_inst (
		.ent_oper_i (ent_oper),
		.rd_oper_i  (rd_oper),
		.result_i   (result_i),
		.cap_oper_o (cap_oper)
	);

	phys_regfile phys_regfile_inst (
		.clk         (clk),
		.rst         (rst),
		.req_tag_i   (req_tag),
		.req_v_i     (req_v),
		.alloc_tag_i (alloc_tag),
		.alloc_v_i   (alloc_v),
		.result_i    (result_i),
		.rd_oper_o   (rd_oper)
	);

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// Testbench clock and reset
// 10 ns clock, reset held high for the first 16 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	// Synchronous reset, released on a rising edge
	initial begin
		rst_o = 1'b1;
		repeat (16) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

// File: dv/rs_chk.sv
// Reservation station checker
// Issue gating by stall, allocation only on accepted dispatch,
// read requests only for operands still waiting
`timescale 1ns/1ns
`default_nettype none

module rs_chk import rs_pkg::*; (
	input logic               clk,
	input logic               rst,
	input logic               stall_i,
	input logic               issue_i,
	input preg_t              alloc_tag_i,
	input logic               alloc_v_i,
	input ent_arr_t           ent_i,
	input rdport_tag_t        req_tag_i,
	input logic [NRDPORT-1:0] req_v_i
);

	logic req_ok;

	// Tag belongs to an uncaptured operand of a busy entry
	function automatic logic waiting_tag(ent_arr_t ents, preg_t tag);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < NRSE; i++)
			for (int s = 0; s < NSRC; s++)
				if (ents[i].busy && !ents[i].src[s].v && ents[i].src[s].tag == tag)
					hit = 1'b1;
		return hit;
	endfunction

	// Some busy entry owns this destination
	function automatic logic dst_held(ent_arr_t ents, preg_t tag);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < NRSE; i++)
			if (ents[i].busy && ents[i].dst == tag)
				hit = 1'b1;
		return hit;
	endfunction

	always_comb begin
		req_ok = 1'b1;
		for (int p = 0; p < NRDPORT; p++)
			req_ok = req_ok & (!req_v_i[p] || waiting_tag(ent_i, req_tag_i[p]));
	end

	// ==============================
	// Properties
	// ==============================

	// Registered pulse, so it follows the gating edge by one cycle
	a_issue_stall: assert property (@(posedge clk) disable iff (rst)
		(stall_i || $past(stall_i)) |=> !issue_i)
		else $error("issue_o pulsed inside a stall window");

	// Accepted micro-op sits in an entry right after the allocating edge
	a_alloc: assert property (@(posedge clk) disable iff (rst)
		alloc_v_i |=> dst_held(ent_i, $past(alloc_tag_i)))
		else $error("alloc_v raised without an accepted dispatch");

	a_req: assert property (@(posedge clk) disable iff (rst) req_ok)
		else $error("read request for an operand that is not waiting");

endmodule

`default_nettype wire

// File: dv/rs_tb.sv
// Reservation station testbench
// Acts as renamer, functional unit and ROB, scoreboards every issue
`timescale 1ns/1ns
`default_nettype none

module rs_tb import rs_pkg::*; ();

	logic clk;
	logic rst;
	lane_arr_t dispatch;
	logic available;
	logic stall;
	rob_mask_t stomp;
	byp_arr_t result;
	logic busy;
	logic issue;
	rs_entry_t issue_entry;

	// Stomp mask as the DUT saw it at the last edge
	rob_mask_t stomp_q = '0;
	logic [31:0] lcg_state = 32'h84f47e72;
	rob_idx_t rndx_ctr = '0;
	// Renamer view of register values
	value_t model_val [NPREG];
	// Scoreboard keyed by ROB index
	rs_entry_t sb_ent [16];
	logic [15:0] sb_valid = '0;
	int sb_count = 0;
	int issue_cnt = 0;
	int chk_cnt = 0;
	int err_cnt = 0;

	tb_clk_gen tb_clk_gen_inst (
		.clk_o (clk),
		.rst_o (rst)
	);

	rs_top rs_top_inst (
		.clk           (clk),
		.rst           (rst),
		.dispatch_i    (dispatch),
		.available_i   (available),
		.stall_i       (stall),
		.stomp_i       (stomp),
		.result_i      (result),
		.busy_o        (busy),
		.issue_o       (issue),
		.issue_entry_o (issue_entry)
	);

	bind rs_station rs_chk rs_chk_inst (
		.clk         (clk),
		.rst         (rst),
		.stall_i     (stall_i),
		.issue_i     (issue_o),
		.alloc_tag_i (alloc_tag_o),
		.alloc_v_i   (alloc_v_o),
		.ent_i       (ent),
		.req_tag_i   (req_tag_o),
		.req_v_i     (req_v_o)
	);

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic funcunit_t other_fu();
		return funcunit_t'(MY_FUNCUNIT + 1 + next_rand() % 7);
	endfunction

	// Sources live in 0..15, destinations in 16..31
	function automatic preg_t src_rand();
		return preg_t'(next_rand() % 16);
	endfunction

	function automatic preg_t dst_rand();
		return preg_t'(16 + next_rand() % 16);
	endfunction

	// Lane micro-op, cap marks the operands handed over already captured
	function automatic rs_entry_t make_uop(funcunit_t fu, preg_t dst, preg_t t0, preg_t t1,
			logic [1:0] cap);
		rs_entry_t u;
		u = '0;
		u.v = 1'b1;
		u.funcunit = fu;
		u.op = opcode_e'(4'(1 + next_rand() % 5));
		u.rndx = rndx_ctr;
		u.dst = dst;
		u.src[0].tag = t0;
		u.src[1].tag = t1;
		for (int s = 0; s < NSRC; s++) begin
			if (cap[s]) begin
				u.src[s].val = next_rand();
				u.src[s].v = 1'b1;
			end
		end
		rndx_ctr = rndx_ctr + rob_idx_t'(1 + next_rand() % 2);
		return u;
	endfunction

	// Reference: waiting operands take the modelled register value
	function automatic rs_entry_t expected_issue(rs_entry_t disp, logic stomp_iss);
		rs_entry_t e;
		e = disp;
		e.busy = 1'b1;
		e.ready = 1'b1;
		for (int s = 0; s < NSRC; s++) begin
			if (!e.src[s].v) begin
				e.src[s].val = model_val[e.src[s].tag];
				e.src[s].v = 1'b1;
			end
		end
		if (stomp_iss) begin
			e.v = 1'b0;
			e.op = OP_NOP;
		end
		return e;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		chk_cnt++;
		assert (got == exp) else begin
			$display("ERR %s got %h exp %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name, input int base);
		if (err_cnt == base)
			$display("test %s: passed", name);
		else
			$display("test %s: %0d failures", name, err_cnt - base);
	endtask

	// Waits for a free entry, offers the lanes for one cycle
	// Returns at the accepting edge
	task automatic offer(input lane_arr_t lanes, input int acc_lane);
		rs_entry_t e;
		int n;
		n = 0;
		@(negedge clk);
		while (busy) begin
			n++;
			if (n > 200)
				abort_run("timeout waiting for a free station entry");
			@(negedge clk);
		end
		@(posedge clk);
		dispatch <= lanes;
		@(negedge clk);
		if (acc_lane >= 0) begin
			e = lanes[acc_lane];
			// Stomped at dispatch turns into a NOP
			if (stomp[e.rndx])
				e.op = OP_NOP;
			sb_ent[e.rndx] = e;
			sb_valid[e.rndx] = 1'b1;
			sb_count++;
		end
		@(posedge clk);
		dispatch <= '0;
	endtask

	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		while (sb_count != 0) begin
			@(negedge clk);
			n++;
			if (n > max_cycles)
				abort_run("timeout waiting for dispatched micro-ops to issue");
		end
	endtask

	// Two result bus writes in one cycle, tags must differ
	task automatic write_pair(input preg_t a, input value_t va, input preg_t b, input value_t vb);
		@(posedge clk);
		result[0] <= '{a, va, 1'b1};
		result[1] <= '{b, vb, 1'b1};
		model_val[a] = va;
		model_val[b] = vb;
		@(posedge clk);
		result <= '0;
	endtask

	// ==============================
	// Issue comparison
	// ==============================

	always @(posedge clk)
		stomp_q <= stomp;

	always @(negedge clk) begin : compare_issue
		rs_entry_t want;
		if (!rst && issue) begin
			chk_cnt++;
			issue_cnt++;
			assert (sb_valid[issue_entry.rndx]) else begin
				$display("issue of rndx %0d which has no waiting dispatch", issue_entry.rndx);
				err_cnt++;
			end
			if (sb_valid[issue_entry.rndx]) begin
				want = expected_issue(sb_ent[issue_entry.rndx], stomp_q[issue_entry.rndx]);
				assert (issue_entry == want) else begin
					$display("ERR issue_entry_o rndx %h got %h exp %h",
						issue_entry.rndx, issue_entry, want);
					err_cnt++;
				end
				sb_valid[issue_entry.rndx] = 1'b0;
				sb_count--;
			end
		end
	end

	// Overall limit on simulated time
	initial begin
		#200000;
		abort_run("simulation time limit reached");
	end

	// ==============================
	// Stimulus
	// ==============================

	initial begin : stimulus
		lane_arr_t lanes;
		rs_entry_t u;
		rs_entry_t w;
		preg_t t;
		preg_t t2;
		value_t bval;
		int base;
		int base_issue;
		int n;
		dispatch = '0;
		available = 1'b0;
		stall = 1'b0;
		stomp = '0;
		result = '0;
		for (int r = 0; r < NPREG; r++)
			model_val[r] = '0;
		n = 0;
		@(negedge clk);
		while (rst) begin
			n++;
			if (n > 100)
				abort_run("timeout waiting for reset release");
			@(negedge clk);
		end
		@(posedge clk);
		available <= 1'b1;

		// Captured operands, issue two edges after the accept
		base = err_cnt;
		repeat (3) begin
			lanes = '0;
			lanes[0] = make_uop(funcunit_t'(MY_FUNCUNIT), dst_rand(), src_rand(), src_rand(), 2'b11);
			offer(lanes, 0);
			@(negedge clk);
			check_eq("issue_o", issue, 1'b0);
			@(negedge clk);
			check_eq("issue_o", issue, 1'b0);
			@(negedge clk);
			check_eq("issue_o", issue, 1'b1);
			wait_drain(20);
		end
		report_test("ready operands", base);

		// Foreign unit held on a lane is never taken
		base = err_cnt;
		lanes = '0;
		lanes[0] = make_uop(other_fu(), dst_rand(), src_rand(), src_rand(), 2'b11);
		@(posedge clk);
		dispatch <= lanes;
		repeat (6) @(posedge clk);
		dispatch <= '0;
		// Both lanes match, lane 1 wins
		lanes[0] = make_uop(funcunit_t'(MY_FUNCUNIT), dst_rand(), src_rand(), src_rand(), 2'b11);
		lanes[1] = make_uop(funcunit_t'(MY_FUNCUNIT), dst_rand(), src_rand(), src_rand(), 2'b11);
		offer(lanes, 1);
		lanes[0] = make_uop(funcunit_t'(MY_FUNCUNIT), dst_rand(), src_rand(), src_rand(), 2'b11);
		lanes[1] = make_uop(other_fu(), dst_rand(), src_rand(), src_rand(), 2'b11);
		offer(lanes, 0);
		wait_drain(40);
		report_test("lane and unit selection", base);

		// Operands fetched through the register read ports
		// Both slots, then slot 1 only, then slot 0 only left waiting
		base = err_cnt;
		for (int k = 0; k < 6; k++) begin
			t = src_rand();
			t2 = preg_t'((t + 1 + next_rand() % 15) % 16);
			write_pair(t, next_rand(), t2, next_rand());
			lanes = '0;
			lanes[0] = make_uop(funcunit_t'(MY_FUNCUNIT), dst_rand(), t, t2,
				2'(k % 3));
			offer(lanes, 0);
			wait_drain(30);
		end
		report_test("register read path", base);

		// Consumer of a pending producer waits for the broadcast
		base = err_cnt;
		t = dst_rand();
		lanes = '0;
		u = make_uop(funcunit_t'(MY_FUNCUNIT), t, src_rand(), src_rand(), 2'b11);
		lanes[0] = u;
		offer(lanes, 0);
		w = make_uop(funcunit_t'(MY_FUNCUNIT), dst_rand(), src_rand(), t, 2'b01);
		lanes[0] = w;
		offer(lanes, 0);
		repeat (8) @(negedge clk);
		chk_cnt++;
		assert (sb_valid[w.rndx]) else begin
			$display("consumer of tag %0d issued before the tag was broadcast", t);
			err_cnt++;
		end
		bval = next_rand();
		n = next_rand() % 2;
		@(posedge clk);
		result[n] <= '{t, bval, 1'b1};
		model_val[t] = bval;
		@(posedge clk);
		result <= '0;
		wait_drain(30);
		report_test("wakeup by result bus", base);

		// Fill under stall, overflow offer must be refused
		base = err_cnt;
		base_issue = issue_cnt;
		@(posedge clk);
		stall <= 1'b1;
		repeat (4) begin
			lanes = '0;
			n = next_rand() % 2;
			lanes[n] = make_uop(funcunit_t'(MY_FUNCUNIT), dst_rand(), src_rand(), src_rand(), 2'b11);
			offer(lanes, n);
		end
		@(negedge clk);
		check_eq("busy_o", busy, 1'b1);
		lanes = '0;
		lanes[1] = make_uop(funcunit_t'(MY_FUNCUNIT), dst_rand(), src_rand(), src_rand(), 2'b11);
		@(posedge clk);
		dispatch <= lanes;
		repeat (4 + next_rand() % 8) begin
			@(negedge clk);
			check_eq("busy_o", busy, 1'b1);
			check_eq("issue_o", issue, 1'b0);
		end
		// Offer withdrawn in the same edge that ends the stall
		@(posedge clk);
		dispatch <= '0;
		stall <= 1'b0;
		wait_drain(40);
		repeat (5) @(negedge clk);
		check_eq("issue count", issue_cnt - base_issue, 4);
		check_eq("busy_o", busy, 1'b0);
		report_test("stall and full", base);

		// Both stomped at dispatch, only u still stomped when they issue
		base = err_cnt;
		u = make_uop(funcunit_t'(MY_FUNCUNIT), dst_rand(), src_rand(), src_rand(), 2'b11);
		w = make_uop(funcunit_t'(MY_FUNCUNIT), dst_rand(), src_rand(), src_rand(), 2'b11);
		@(posedge clk);
		stomp <= (rob_mask_t'(1) << u.rndx) | (rob_mask_t'(1) << w.rndx);
		stall <= 1'b1;
		lanes = '0;
		lanes[0] = u;
		offer(lanes, 0);
		lanes[0] = w;
		offer(lanes, 0);
		// w keeps its NOP but issues valid
		@(posedge clk);
		stomp <= rob_mask_t'(1) << u.rndx;
		stall <= 1'b0;
		wait_drain(30);
		// Stomp raised only while the entry waits under stall
		@(posedge clk);
		stomp <= '0;
		stall <= 1'b1;
		u = make_uop(funcunit_t'(MY_FUNCUNIT), dst_rand(), src_rand(), src_rand(), 2'b11);
		lanes[0] = u;
		offer(lanes, 0);
		@(posedge clk);
		stomp <= rob_mask_t'(1) << u.rndx;
		@(posedge clk);
		stall <= 1'b0;
		wait_drain(30);
		@(posedge clk);
		stomp <= '0;
		report_test("stomp", base);

		repeat (4) @(negedge clk);
		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
src/rs_pkg.sv
src/operand_capture.sv
src/phys_regfile.sv
src/rs_station.sv
src/rs_top.sv
dv/tb_clk_gen.sv
dv/rs_chk.sv
dv/rs_tb.sv
